//--- Makefile
# Verilator simulation of the 802.11a transmit bit encoder

VERILATOR ?= verilator
TOP       ?= tb_dot11_tx_encoder
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# The simulation binary exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/conv_encoder_out.sv
`timescale 1ns/1ps

module conv_encoder_out
    import dot11_phy_pkg::*;
(
    input  logic        clk,
    input  logic        reset_int,
    input  logic        i_bit,
    input  logic        i_bit_valid,
    input  logic        i_bit_first,
    input  logic        i_bit_last,
    output logic        o_bit_ready,
    output coded_pair_t o_bits,
    output logic        o_valid,
    input  logic        i_ready,
    output logic        o_done
);

    logic [5:0]  shift_q;
    logic [5:0]  shift_eff;
    logic        last_q;
    logic        accept;
    coded_pair_t pair;

    //////////////////////////////////////////////////
    // K=7 rate 1/2 code
    //////////////////////////////////////////////////

    // Bit 0 of the shift register is the most recent input
    assign shift_eff = i_bit_first ? 6'b0 : shift_q;

    assign pair[0] = i_bit ^ shift_eff[1] ^ shift_eff[2] ^ shift_eff[4] ^ shift_eff[5];
    assign pair[1] = i_bit ^ shift_eff[0] ^ shift_eff[1] ^ shift_eff[2] ^ shift_eff[5];

    // Slot takes a new pair when empty or draining this cycle
    assign o_bit_ready = !o_valid || i_ready;
    assign accept      = i_bit_valid && o_bit_ready;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            shift_q <= '0;
            o_valid <= 1'b0;
            last_q  <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_done <= o_valid && i_ready && last_q;
            if (accept) begin
                // Zeroed after the last bit so the next packet starts clean
                shift_q <= i_bit_last ? 6'b0 : {shift_eff[4:0], i_bit};
                o_valid <= 1'b1;
                last_q  <= i_bit_last;
            end else if (i_ready) begin
                o_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_bits <= pair;
        end
    end

    a_valid_hold: assert property (@(posedge clk) disable iff (reset_int)
        o_valid && !i_ready |=> o_valid && $stable(o_bits));

endmodule

//--- hdl/dot11_ctrl_pkg.sv
package dot11_ctrl_pkg;

    // Framer sequence, one state per transmitted field
    typedef enum logic [2:0] {
        IDLE,
        SIGNAL,
        SERVICE,
        PSDU,
        FCS,
        TAIL,
        PAD,
        LAST
    } framer_state_t;

    // Bit position inside the current field, wide enough for a 65535 byte PSDU
    typedef logic [18:0] bit_cnt_t;

endpackage

//--- hdl/dot11_phy_pkg.sv
`include "dot11_tx_macros.svh"

package dot11_phy_pkg;

    typedef logic [`DOT11_WORD_W-1:0] ram_word_t;
    typedef logic [`DOT11_ADDR_W-1:0] ram_addr_t;
    typedef logic [3:0]               rate_code_t;
    typedef logic [8:0]               dbps_t;
    typedef logic [18:0]              psdu_bits_t;
    // Bit 0 is g0 (133 octal), bit 1 is g1 (171 octal)
    typedef logic [1:0]               coded_pair_t;
    typedef logic [6:0]               scram_state_t;

    // Data bits per OFDM symbol, unknown codes fall back to 6 Mbps
    function automatic dbps_t rate_to_dbps(input rate_code_t rate);
        case (rate)
            4'b1011: return dbps_t'(24);
            4'b1111: return dbps_t'(36);
            4'b1010: return dbps_t'(48);
            4'b1110: return dbps_t'(72);
            4'b1001: return dbps_t'(96);
            4'b1101: return dbps_t'(144);
            4'b1000: return dbps_t'(192);
            4'b1100: return dbps_t'(216);
            default: return dbps_t'(24);
        endcase
    endfunction

endpackage

//--- hdl/dot11_tx_encoder.sv
`timescale 1ns/1ps

module dot11_tx_encoder
    import dot11_phy_pkg::*;
(
    input  logic         clk,
    input  logic         reset_int,
    input  logic         i_start,
    input  scram_state_t i_data_scram_init,
    input  ram_word_t    i_bram_din,
    output ram_addr_t    o_bram_addr,
    output coded_pair_t  o_bits,
    output logic         o_valid,
    input  logic         i_ready,
    output logic         o_done
);

    logic       capture;
    dbps_t      dbps;
    psdu_bits_t psdu_bits;
    logic       enc_bit;
    logic       enc_bit_valid;
    logic       enc_bit_first;
    logic       enc_bit_last;
    logic       enc_bit_ready;

    sig_field_decode u_decode (
        .clk         (clk),
        .reset_int   (reset_int),
        .i_capture   (capture),
        .i_word      (i_bram_din),
        .o_dbps      (dbps),
        .o_psdu_bits (psdu_bits)
    );

    tx_bit_framer u_framer (
        .clk               (clk),
        .reset_int         (reset_int),
        .i_start           (i_start),
        .i_data_scram_init (i_data_scram_init),
        .i_bram_din        (i_bram_din),
        .o_bram_addr       (o_bram_addr),
        .o_capture         (capture),
        .i_dbps            (dbps),
        .i_psdu_bits       (psdu_bits),
        .o_bit             (enc_bit),
        .o_bit_valid       (enc_bit_valid),
        .o_bit_first       (enc_bit_first),
        .o_bit_last        (enc_bit_last),
        .i_bit_ready       (enc_bit_ready)
    );

    conv_encoder_out u_encoder (
        .clk         (clk),
        .reset_int   (reset_int),
        .i_bit       (enc_bit),
        .i_bit_valid (enc_bit_valid),
        .i_bit_first (enc_bit_first),
        .i_bit_last  (enc_bit_last),
        .o_bit_ready (enc_bit_ready),
        .o_bits      (o_bits),
        .o_valid     (o_valid),
        .i_ready     (i_ready),
        .o_done      (o_done)
    );

endmodule

//--- hdl/dot11_tx_macros.svh
`ifndef DOT11_TX_MACROS_SVH
`define DOT11_TX_MACROS_SVH

// Block RAM geometry
`define DOT11_WORD_W 64
`define DOT11_ADDR_W 12

// Field lengths in bits
`define DOT11_SIG_BITS 24
`define DOT11_SERVICE_BITS 16
`define DOT11_TAIL_BITS 6
`define DOT11_FCS_BITS 32

// Byte length inside the SIGNAL word, bits 16:5
`define DOT11_LEN_LSB 5
`define DOT11_LEN_W 12

// First PSDU word in the packet RAM
`define DOT11_PSDU_ADDR 2

`endif

//--- hdl/sig_field_decode.sv
`timescale 1ns/1ps

`include "dot11_tx_macros.svh"

module sig_field_decode
    import dot11_phy_pkg::*;
(
    input  logic       clk,
    input  logic       reset_int,
    input  logic       i_capture,
    input  ram_word_t  i_word,
    output dbps_t      o_dbps,
    output psdu_bits_t o_psdu_bits
);

    rate_code_t                  rate_q;
    logic [`DOT11_LEN_W-1:0]     len_q;

    //////////////////////////////////////////////////
    // SIGNAL word capture
    //////////////////////////////////////////////////

    // Rate sits in the low nibble, length in bytes above the reserved bit
    always_ff @(posedge clk) begin
        if (reset_int) begin
            rate_q <= '0;
            len_q  <= '0;
        end else if (i_capture) begin
            rate_q <= i_word[$bits(rate_code_t)-1:0];
            len_q  <= i_word[`DOT11_LEN_LSB +: `DOT11_LEN_W];
        end
    end

    //////////////////////////////////////////////////
    // Field translation
    //////////////////////////////////////////////////

    always_comb begin
        o_dbps = rate_to_dbps(rate_q);
    end

    // Bytes to bits, the count still includes the FCS
    always_comb begin
        o_psdu_bits = psdu_bits_t'({len_q, 3'b000});
    end

endmodule

//--- hdl/tx_bit_framer.sv
`timescale 1ns/1ps

`include "dot11_tx_macros.svh"

module tx_bit_framer
    import dot11_phy_pkg::*;
    import dot11_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset_int,
    input  logic         i_start,
    input  scram_state_t i_data_scram_init,
    input  ram_word_t    i_bram_din,
    output ram_addr_t    o_bram_addr,
    output logic         o_capture,
    input  dbps_t        i_dbps,
    input  psdu_bits_t   i_psdu_bits,
    output logic         o_bit,
    output logic         o_bit_valid,
    output logic         o_bit_first,
    output logic         o_bit_last,
    input  logic         i_bit_ready
);

    localparam bit_cnt_t SIG_LAST     = bit_cnt_t'(`DOT11_SIG_BITS - 1);
    localparam bit_cnt_t SERVICE_LAST = bit_cnt_t'(`DOT11_SERVICE_BITS - 1);
    localparam bit_cnt_t FCS_LAST     = bit_cnt_t'(`DOT11_FCS_BITS - 1);
    localparam bit_cnt_t TAIL_LAST    = bit_cnt_t'(`DOT11_TAIL_BITS - 1);
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB88320;

    framer_state_t               state;
    logic                        sig_wait;
    bit_cnt_t                    bit_cnt;
    dbps_t                       sym_cnt;
    scram_state_t                scram_q;
    logic [`DOT11_FCS_BITS-1:0]  crc_q;
    logic [`DOT11_FCS_BITS-1:0]  crc_nxt;
    logic [3:0]                  last_nibble;
    logic                        xfer;
    logic                        sym_wrap;
    logic                        scram_fb;
    logic                        psdu_bit;

    assign xfer     = o_bit_valid && i_bit_ready;
    assign sym_wrap = (sym_cnt == dbps_t'(i_dbps - 9'd1));
    assign scram_fb = scram_q[6] ^ scram_q[3];

    // Top nibble is read from a copy taken before the address moves on
    assign psdu_bit = (bit_cnt[5:2] == 4'hF) ? last_nibble[bit_cnt[1:0]]
                                             : i_bram_din[bit_cnt[5:0]];

    assign crc_nxt = {1'b0, crc_q[31:1]} ^ ((crc_q[0] ^ psdu_bit) ? CRC_POLY_REFL : 32'h0);

    //////////////////////////////////////////////////
    // Handshake and bit source
    //////////////////////////////////////////////////

    assign o_bit_valid = (state != IDLE) && (state != LAST) && !sig_wait;
    assign o_capture   = (state == SIGNAL) && !sig_wait && (bit_cnt == '0);
    assign o_bit_first = (state == SERVICE) && (bit_cnt == '0);
    // Final bit of the packet, the last tail bit when no pad is needed
    assign o_bit_last  = sym_wrap && ((state == PAD) ||
                                      ((state == TAIL) && (bit_cnt == TAIL_LAST)));

    always_comb begin
        case (state)
            SIGNAL:       o_bit = i_bram_din[bit_cnt[4:0]];
            SERVICE, PAD: o_bit = scram_fb;
            PSDU:         o_bit = scram_fb ^ psdu_bit;
            FCS:          o_bit = scram_fb ^ ~crc_q[bit_cnt[4:0]];
            default:      o_bit = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Field sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_int) begin
            state       <= IDLE;
            sig_wait    <= 1'b0;
            bit_cnt     <= '0;
            sym_cnt     <= '0;
            o_bram_addr <= '0;
        end else begin
            sig_wait <= 1'b0;
            case (state)
                IDLE: begin
                    // Word 0 shows up on the RAM port one cycle after the address
                    if (i_start) begin
                        state       <= SIGNAL;
                        sig_wait    <= 1'b1;
                        bit_cnt     <= '0;
                        o_bram_addr <= '0;
                    end
                end
                SIGNAL: begin
                    if (xfer) begin
                        if (bit_cnt == SIG_LAST) begin
                            state       <= SERVICE;
                            bit_cnt     <= '0;
                            sym_cnt     <= '0;
                            o_bram_addr <= ram_addr_t'(`DOT11_PSDU_ADDR);
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                SERVICE: begin
                    if (xfer) begin
                        if (bit_cnt == SERVICE_LAST) begin
                            bit_cnt <= '0;
                            state   <= (i_psdu_bits > psdu_bits_t'(`DOT11_FCS_BITS)) ? PSDU : FCS;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PSDU: begin
                    if (xfer) begin
                        if (bit_cnt[5:0] == 6'd62) begin
                            o_bram_addr <= o_bram_addr + 1'b1;
                        end
                        if (bit_cnt == bit_cnt_t'(i_psdu_bits - 19'd33)) begin
                            state   <= FCS;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                FCS: begin
                    if (xfer) begin
                        if (bit_cnt == FCS_LAST) begin
                            state   <= TAIL;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TAIL: begin
                    if (xfer) begin
                        if (bit_cnt == TAIL_LAST) begin
                            bit_cnt <= '0;
                            state   <= sym_wrap ? LAST : PAD;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PAD: begin
                    if (xfer && sym_wrap) begin
                        state <= LAST;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            // Data bits modulo N_DBPS, SIGNAL is its own symbol
            if (xfer && (state != SIGNAL)) begin
                sym_cnt <= sym_wrap ? '0 : sym_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Scrambler and FCS
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (xfer && (state == SIGNAL) && (bit_cnt == SIG_LAST)) begin
            scram_q <= i_data_scram_init;
            crc_q   <= '1;
        end else if (xfer && (state inside {SERVICE, PSDU, FCS, PAD})) begin
            // Tail bits leave the scrambler untouched
            scram_q <= {scram_q[5:0], scram_fb};
        end
        if (xfer && (state == PSDU)) begin
            crc_q <= crc_nxt;
            if (bit_cnt[5:0] == 6'd59) begin
                last_nibble <= i_bram_din[63:60];
            end
        end
    end

    a_bit_stable: assert property (@(posedge clk) disable iff (reset_int)
        o_bit_valid && !i_bit_ready |=> o_bit_valid && $stable(o_bit));

    // A zero length pad goes from TAIL straight to LAST
    a_pad_entry: assert property (@(posedge clk) disable iff (reset_int)
        $rose(state == PAD) |-> sym_cnt != '0);

endmodule

//--- test/tb_dot11_tx_encoder.sv
`timescale 1ns/1ps

`include "dot11_tx_macros.svh"

module tb_dot11_tx_encoder
    import dot11_phy_pkg::*;
();

    localparam int CLK_HALF  = 4;
    localparam int DRIVE_DLY = 1;
    // All eight legal rate codes, then a reserved one
    localparam rate_code_t SWEEP_RATES [9] = '{4'b1011, 4'b1111, 4'b1010, 4'b1110,
                                               4'b1001, 4'b1101, 4'b1000, 4'b1100, 4'b0111};

    logic         clk;
    logic         reset_int;
    logic         i_start;
    scram_state_t i_data_scram_init;
    ram_word_t    i_bram_din;
    ram_addr_t    o_bram_addr;
    coded_pair_t  o_bits;
    logic         o_valid;
    logic         i_ready;
    logic         o_done;

    ram_word_t    mem [0:(1 << `DOT11_ADDR_W) - 1];
    ram_addr_t    addr_seen;
    coded_pair_t  exp_mem [$];
    int           exp_count;
    int           pair_cnt;
    int           done_total;
    logic         done_due;
    logic         idle_phase;
    logic         pkt_active;
    longint       cycle_cnt;
    longint       deadline;
    logic [5:0]   conv_past;
    logic [7:1]   scr;
    logic [31:0]  crc_reg;

    dot11_tx_encoder dot11_tx_encoder_i (
        .clk               (clk),
        .reset_int         (reset_int),
        .i_start           (i_start),
        .i_data_scram_init (i_data_scram_init),
        .i_bram_din        (i_bram_din),
        .o_bram_addr       (o_bram_addr),
        .o_bits            (o_bits),
        .o_valid           (o_valid),
        .i_ready           (i_ready),
        .o_done            (o_done)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic int dbps_for_rate(input rate_code_t rate);
        case (rate)
            4'b1011: return 24;
            4'b1111: return 36;
            4'b1010: return 48;
            4'b1110: return 72;
            4'b1001: return 96;
            4'b1101: return 144;
            4'b1000: return 192;
            4'b1100: return 216;
            default: return 24;
        endcase
    endfunction

    function automatic int expected_pairs(input int dbps, input int len_bytes);
        int data_bits;
        data_bits = `DOT11_SERVICE_BITS + 8 * len_bytes + `DOT11_TAIL_BITS;
        return `DOT11_SIG_BITS + dbps * ((data_bits + dbps - 1) / dbps);
    endfunction

    // Window bit 6 is the newest input, bit 0 the oldest
    task automatic push_coded(input logic b);
        logic [6:0]  win;
        coded_pair_t pair;
        win       = {b, conv_past};
        pair[0]   = ^(win & 7'o133);
        pair[1]   = ^(win & 7'o171);
        conv_past = win[6:1];
        exp_mem.push_back(pair);
    endtask

    task automatic push_scrambled(input logic b);
        logic fb;
        fb  = scr[7] ^ scr[4];
        scr = {scr[6:1], fb};
        push_coded(b ^ fb);
    endtask

    task automatic build_expected(input int len_bytes, input int dbps, input scram_state_t seed);
        ram_word_t  sig;
        ram_addr_t  word_addr;
        logic [5:0] bit_pos;
        logic       b;
        logic       fb;
        int         k;
        int         pad_bits;
        exp_mem.delete();
        sig       = mem[0];
        conv_past = '0;
        for (k = 0; k < `DOT11_SIG_BITS; k++) begin
            push_coded(sig[6'(k)]);
        end
        // DATA restarts the encoder and seeds scrambler and CRC
        conv_past = '0;
        scr       = seed;
        crc_reg   = '1;
        for (k = 0; k < `DOT11_SERVICE_BITS; k++) begin
            push_scrambled(1'b0);
        end
        for (k = 0; k < 8 * len_bytes - `DOT11_FCS_BITS; k++) begin
            word_addr = ram_addr_t'(2 + k / 64);
            bit_pos   = 6'(k % 64);
            b         = mem[word_addr][bit_pos];
            fb        = crc_reg[31] ^ b;
            crc_reg   = {crc_reg[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
            push_scrambled(b);
        end
        for (k = 0; k < `DOT11_FCS_BITS; k++) begin
            push_scrambled(~crc_reg[5'(31 - k)]);
        end
        // Tail goes out as plain zeros and the scrambler holds
        for (k = 0; k < `DOT11_TAIL_BITS; k++) begin
            push_coded(1'b0);
        end
        k        = `DOT11_SERVICE_BITS + 8 * len_bytes + `DOT11_TAIL_BITS;
        pad_bits = (dbps - k % dbps) % dbps;
        for (k = 0; k < pad_bits; k++) begin
            push_scrambled(1'b0);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic load_packet(input rate_code_t rate, input int len_bytes);
        ram_word_t sig;
        int        a;
        sig       = '0;
        sig[3:0]  = rate;
        sig[16:5] = len_bytes[11:0];
        sig[17]   = ^sig[16:0];
        mem[0]    = sig;
        for (a = 1; a < 2 + (len_bytes * 8 + 63) / 64; a++) begin
            mem[ram_addr_t'(a)] = {$urandom, $urandom} ^ (64'(a) * 64'h9E37_79B9_7F4A_7C15);
        end
    endtask

    task automatic run_packet(input rate_code_t rate, input int len_bytes);
        scram_state_t seed;
        int           want;
        seed = scram_state_t'(1 + ($urandom % 127));
        load_packet(rate, len_bytes);
        build_expected(len_bytes, dbps_for_rate(rate), seed);
        exp_count  = expected_pairs(dbps_for_rate(rate), len_bytes);
        want       = done_total + 1;
        deadline   = cycle_cnt + 20 * exp_mem.size() + 100;
        pkt_active = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        i_start           = 1'b1;
        i_data_scram_init = seed;
        @(posedge clk);
        #DRIVE_DLY;
        i_start = 1'b0;
        while (done_total < want) begin
            @(posedge clk);
        end
        pkt_active = 1'b0;
        repeat (2 + ($urandom % 4)) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Block RAM with one cycle of read latency
    initial begin
        addr_seen  = '0;
        i_bram_din = '0;
        forever begin
            @(negedge clk);
            addr_seen = o_bram_addr;
            @(posedge clk);
            #DRIVE_DLY;
            i_bram_din = mem[addr_seen];
        end
    end

    initial begin
        i_ready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            i_ready = (($urandom % 4) != 0);
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_stall_hold: assert property (@(posedge clk) disable iff (reset_int)
        o_valid && !i_ready |=> o_valid && $stable(o_bits))
        else fail_run("o_bits or o_valid changed while the output stream was stalled");

    initial begin
        pair_cnt   = 0;
        done_total = 0;
        done_due   = 1'b0;
        idle_phase = 1'b1;
        forever begin
            @(negedge clk);
            if (!reset_int) begin
                if (i_start) begin
                    pair_cnt   = 0;
                    idle_phase = 1'b0;
                end
                // Pair count is judged first so an early or late pulse reports it
                if (o_done) begin
                    assert (pair_cnt == exp_count) else fail_run($sformatf(
                        "ERR %0t o_bits pair count got %0d expected %0d",
                        $time, pair_cnt, exp_count));
                    done_total = done_total + 1;
                    idle_phase = 1'b1;
                end
                assert (o_done == done_due) else fail_run($sformatf(
                    "ERR %0t o_done got %b expected %b", $time, o_done, done_due));
                assert (!(idle_phase && o_valid))
                    else fail_run("o_valid went high after o_done and before the next start");
                done_due = 1'b0;
                if (o_valid && i_ready) begin
                    assert (pair_cnt < exp_mem.size())
                        else fail_run("the DUT sent more pairs than the packet holds");
                    assert (o_bits == exp_mem[pair_cnt]) else fail_run($sformatf(
                        "ERR %0t o_bits pair %0d got %b expected %b",
                        $time, pair_cnt, o_bits, exp_mem[pair_cnt]));
                    pair_cnt = pair_cnt + 1;
                    done_due = (pair_cnt == exp_mem.size());
                end
            end
        end
    end

    // Budget per packet is 20 cycles per pair plus 100
    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
            if (pkt_active && (cycle_cnt > deadline)) begin
                fail_run("watchdog expired because o_done did not arrive in time");
            end
        end
    end

    initial begin
        int a;
        int i;
        void'($urandom(78436));
        reset_int         = 1'b1;
        i_start           = 1'b0;
        i_data_scram_init = '0;
        pkt_active        = 1'b0;
        deadline          = 0;
        exp_count         = 0;
        for (a = 0; a < (1 << `DOT11_ADDR_W); a++) begin
            mem[ram_addr_t'(a)] = ~(64'(a) * 64'hC2B2_AE3D_27D4_EB4F);
        end
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        reset_int = 1'b0;
        for (i = 0; i < 9; i++) begin
            run_packet(SWEEP_RATES[4'(i)], 4 + ($urandom % 40));
        end
        // Longer packets that cross several RAM words
        for (i = 0; i < 3; i++) begin
            run_packet(SWEEP_RATES[4'($urandom % 8)], 20 + ($urandom % 160));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/dot11_phy_pkg.sv
hdl/dot11_ctrl_pkg.sv
hdl/sig_field_decode.sv
hdl/tx_bit_framer.sv
hdl/conv_encoder_out.sv
hdl/dot11_tx_encoder.sv
test/tb_dot11_tx_encoder.sv
